// File: rtl/video_pkg.sv
`default_nettype none

package video_pkg;

    // horizontal timing, offscreen clocks come first on each line
    localparam int H_VISIBLE       = 64;
    localparam int H_FRONT_PORCH   = 4;
    localparam int H_SYNC_PULSE    = 8;
    localparam int H_BACK_PORCH    = 12;
    localparam int H_TOTAL         = H_VISIBLE + H_FRONT_PORCH + H_SYNC_PULSE + H_BACK_PORCH;

    // vertical timing, offscreen lines follow the visible ones
    localparam int V_VISIBLE       = 6;
    localparam int V_FRONT_PORCH   = 1;
    localparam int V_SYNC_PULSE    = 2;
    localparam int V_BACK_PORCH    = 2;
    localparam int V_TOTAL         = V_VISIBLE + V_FRONT_PORCH + V_SYNC_PULSE + V_BACK_PORCH;

    localparam logic H_SYNC_POLARITY = 1'b0;    // active low
    localparam logic V_SYNC_POLARITY = 1'b0;    // active low

    localparam int H_FETCH_BEGIN   = 2;         // h count where line fetch begins
    localparam int GROUPS_PER_LINE = H_VISIBLE / 8;
    localparam int COUNT_W         = 11;

    // register numbers
    localparam logic [4:0] XR_VID_CTRL     = 5'h00;
    localparam logic [4:0] XR_SCANLINE     = 5'h08;
    localparam logic [4:0] XR_VID_HSIZE    = 5'h0C;
    localparam logic [4:0] XR_VID_VSIZE    = 5'h0D;
    localparam logic [4:0] XR_PA_GFX_CTRL  = 5'h10;
    localparam logic [4:0] XR_PA_DISP_ADDR = 5'h12;
    localparam logic [4:0] XR_PA_LINE_LEN  = 5'h13;

    localparam logic [15:0] DEFAULT_LINE_LEN = 16'd8;

    typedef enum logic [1:0] {
        PRE_SYNC  = 2'b00,
        SYNC      = 2'b01,
        POST_SYNC = 2'b10,
        VISIBLE   = 2'b11
    } video_state_e;

    typedef enum logic [1:0] {
        BPP_1_ATTR = 2'd0,
        BPP_4      = 2'd2
    } bpp_e;

    typedef struct packed {
        logic               hsync;          // h state is SYNC
        logic               vsync;          // v state is SYNC
        logic               de;             // visible pixel
        logic               vblank;
        video_state_e       h_state;
        logic               line_end;       // last clock of a line
        logic               last_visible;   // last pixel of last visible line
        logic               frame_end;      // last pixel of the frame
        logic               fetch_start;
        logic [COUNT_W-1:0] v_count;
    } timing_t;

    typedef struct packed {
        logic [15:0] disp_addr;
        logic [15:0] line_len;
        logic [7:0]  colorbase;
        bpp_e        bpp;
        logic        blank;
    } plane_cfg_t;

    // one VRAM word, read as attribute + bitmap byte or as four nibbles
    typedef union packed {
        struct packed {
            logic [3:0] back;
            logic [3:0] fore;
            logic [7:0] pixels;     // msb is leftmost pixel
        } attr;
        logic [3:0][3:0] nib;       // nib[3] is leftmost pixel
    } vram_word_u;

    typedef logic [7:0][7:0] pixel_group_t;    // [7] is first pixel

endpackage

`default_nettype wire

// File: rtl/video_timing.sv
`default_nettype none
`timescale 1ns/1ps

module video_timing import video_pkg::*; (
    input  wire logic clk,
    input  wire logic reset_i,
    output timing_t   timing_o
);

    logic [COUNT_W-1:0] h_count;
    logic [COUNT_W-1:0] v_count;
    logic [COUNT_W-1:0] h_end;          // last h count of current h state
    logic [COUNT_W-1:0] v_end;          // last v count of current v state
    video_state_e       h_state;
    video_state_e       v_state;
    logic               line_end;
    logic               v_last;

    always_comb begin
        case (h_state)
            PRE_SYNC:  h_end = COUNT_W'(H_FRONT_PORCH - 1);
            SYNC:      h_end = COUNT_W'(H_FRONT_PORCH + H_SYNC_PULSE - 1);
            POST_SYNC: h_end = COUNT_W'(H_TOTAL - H_VISIBLE - 1);
            default:   h_end = COUNT_W'(H_TOTAL - 1);
        endcase
    end

    always_comb begin
        case (v_state)
            VISIBLE:   v_end = COUNT_W'(V_VISIBLE - 1);
            PRE_SYNC:  v_end = COUNT_W'(V_VISIBLE + V_FRONT_PORCH - 1);
            SYNC:      v_end = COUNT_W'(V_VISIBLE + V_FRONT_PORCH + V_SYNC_PULSE - 1);
            default:   v_end = COUNT_W'(V_TOTAL - 1);
        endcase
    end

    assign line_end = (h_count == COUNT_W'(H_TOTAL - 1));
    assign v_last   = (v_count == v_end);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count <= '0;
            v_count <= '0;
            h_state <= PRE_SYNC;
            v_state <= VISIBLE;                 // line 0 is visible
        end else begin
            h_count <= line_end ? '0 : h_count + 1'b1;
            if (h_count == h_end) begin
                h_state <= video_state_e'(h_state + 2'd1);  // wraps to PRE_SYNC
            end
            if (line_end) begin
                v_count <= (v_count == COUNT_W'(V_TOTAL - 1)) ? '0 : v_count + 1'b1;
                if (v_last) begin
                    v_state <= video_state_e'(v_state + 2'd1);
                end
            end
        end
    end

    always_comb begin
        timing_o.hsync        = (h_state == SYNC);
        timing_o.vsync        = (v_state == SYNC);
        timing_o.vblank       = (v_state != VISIBLE);
        timing_o.de           = (h_state == VISIBLE) && (v_state == VISIBLE);
        timing_o.h_state      = h_state;
        timing_o.line_end     = line_end;
        timing_o.last_visible = line_end && v_last && (v_state == VISIBLE);
        timing_o.frame_end    = line_end && v_last && (v_state == POST_SYNC);
        timing_o.fetch_start  = (v_state == VISIBLE) && (h_count == COUNT_W'(H_FETCH_BEGIN));
        timing_o.v_count      = v_count;
    end

endmodule

`default_nettype wire

// File: rtl/video_regs.sv
`default_nettype none
`timescale 1ns/1ps

module video_regs import video_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset_i,
    input  wire logic        reg_wr_i,
    input  wire logic [4:0]  reg_num_w_i,
    input  wire logic [4:0]  reg_num_r_i,
    input  wire logic [15:0] reg_data_i,
    output logic      [15:0] reg_data_o,
    input  wire timing_t     timing_i,
    output plane_cfg_t       cfg_o,
    output logic      [7:0]  border_color_o,
    output logic      [3:0]  intr_o
);

    logic hblank;

    assign hblank = (timing_i.h_state != VISIBLE);

    // register writes
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg_o.disp_addr <= 16'h0000;
            cfg_o.line_len  <= DEFAULT_LINE_LEN;
            cfg_o.colorbase <= 8'h00;
            cfg_o.bpp       <= BPP_1_ATTR;
            cfg_o.blank     <= 1'b0;        // plane shown
            border_color_o  <= 8'h00;
            intr_o          <= 4'h0;
        end else begin
            intr_o <= 4'h0;                 // pulses last one clock
            if (reg_wr_i) begin
                case (reg_num_w_i)
                    XR_VID_CTRL: begin
                        border_color_o <= reg_data_i[15:8];
                        intr_o         <= reg_data_i[3:0];    // software trigger
                    end
                    XR_PA_GFX_CTRL: begin
                        cfg_o.colorbase <= reg_data_i[15:8];
                        cfg_o.blank     <= reg_data_i[7];
                        cfg_o.bpp       <= bpp_e'(reg_data_i[5:4]);
                    end
                    XR_PA_DISP_ADDR: begin
                        cfg_o.disp_addr <= reg_data_i;
                    end
                    XR_PA_LINE_LEN: begin
                        cfg_o.line_len  <= reg_data_i;
                    end
                    default: begin
                    end
                endcase
            end
            if (timing_i.last_visible) begin
                intr_o[3] <= 1'b1;          // vsync interrupt
            end
        end
    end

    // registered readback
    always_ff @(posedge clk) begin
        case (reg_num_r_i)
            XR_VID_CTRL:     reg_data_o <= {border_color_o, 8'h00};
            XR_SCANLINE:     reg_data_o <= {timing_i.vblank, hblank, 3'b000, timing_i.v_count};
            XR_VID_HSIZE:    reg_data_o <= 16'(H_VISIBLE);
            XR_VID_VSIZE:    reg_data_o <= 16'(V_VISIBLE);
            XR_PA_GFX_CTRL:  reg_data_o <= {cfg_o.colorbase, cfg_o.blank, 1'b0, cfg_o.bpp, 4'h0};
            XR_PA_DISP_ADDR: reg_data_o <= cfg_o.disp_addr;
            XR_PA_LINE_LEN:  reg_data_o <= cfg_o.line_len;
            default:         reg_data_o <= 16'h0000;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/bitmap_fetch.sv
`default_nettype none
`timescale 1ns/1ps

module bitmap_fetch import video_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset_i,
    input  wire timing_t     timing_i,
    input  wire plane_cfg_t  cfg_i,
    output logic             vram_sel_o,
    output logic      [15:0] vram_addr_o,
    input  wire logic [15:0] vram_data_i,
    output pixel_group_t     group_o,
    output logic             group_valid_o,
    input  wire logic        group_ready_i
);

    plane_cfg_t  cfg;               // copy taken at frame end
    logic        armed;             // set once a frame end has been seen
    logic [15:0] line_start;
    logic [15:0] addr;
    logic [3:0]  groups_left;
    logic [1:0]  step;              // 0 issue, 1 second issue, 2 and 3 data
    logic        bpp4;
    logic        room;
    logic        issue0;
    logic        issue1;
    logic        build;
    vram_word_u  word0;
    vram_word_u  word_in;

    function automatic pixel_group_t expand_attr(input vram_word_u w, input logic [3:0] base);
        pixel_group_t g;
        for (int j = 0; j < 8; j++) begin
            g[j] = {base, w.attr.pixels[j] ? w.attr.fore : w.attr.back};
        end
        return g;
    endfunction

    function automatic pixel_group_t expand_nib(input vram_word_u w0, input vram_word_u w1,
                                                input logic [3:0] base);
        pixel_group_t g;
        for (int j = 0; j < 4; j++) begin
            g[j + 4] = {base, w0.nib[j]};   // first word is left half
            g[j]     = {base, w1.nib[j]};
        end
        return g;
    endfunction

    always_comb begin
        word_in = vram_data_i;
        bpp4    = (cfg.bpp == BPP_4);       // other codes act as 1 bpp
        room    = !group_valid_o || group_ready_i;
        issue0  = (step == 2'd0) && (groups_left != 4'd0) && room;
        issue1  = (step == 2'd1) && bpp4;
        build   = ((step == 2'd2) && !bpp4) || (step == 2'd3);
    end

    // sequencing
    always_ff @(posedge clk) begin
        if (reset_i) begin
            armed         <= 1'b0;
            groups_left   <= 4'd0;
            step          <= 2'd0;
            vram_sel_o    <= 1'b0;
            group_valid_o <= 1'b0;
        end else begin
            vram_sel_o <= issue0 || issue1;
            if (group_valid_o && group_ready_i) begin
                group_valid_o <= 1'b0;
            end
            if (issue0) begin
                groups_left <= groups_left - 4'd1;
                step        <= 2'd1;
            end else if (step == 2'd1) begin
                step <= 2'd2;
            end else if (step == 2'd2 && bpp4) begin
                step <= 2'd3;
            end else if (build) begin
                group_valid_o <= 1'b1;
                step          <= 2'd0;
            end
            if (timing_i.fetch_start && armed && !cfg.blank) begin
                groups_left <= 4'(GROUPS_PER_LINE);
            end
            if (timing_i.frame_end) begin
                armed <= 1'b1;
            end
        end
    end

    // addresses and pixel data
    always_ff @(posedge clk) begin
        if (issue0 || issue1) begin
            vram_addr_o <= addr;
            addr        <= addr + 16'd1;
        end
        if (step == 2'd2) begin
            word0 <= word_in;
        end
        if (build) begin
            group_o <= bpp4 ? expand_nib(word0, word_in, cfg.colorbase[7:4])
                            : expand_attr(word_in, cfg.colorbase[7:4]);
        end
        if (timing_i.fetch_start) begin
            addr <= line_start;
        end
        if (timing_i.frame_end) begin
            cfg        <= cfg_i;
            line_start <= cfg_i.disp_addr;
        end else if (timing_i.line_end && !timing_i.vblank) begin
            line_start <= line_start + cfg.line_len;
        end
    end

endmodule

`default_nettype wire

// File: rtl/pixel_scanout.sv
`default_nettype none
`timescale 1ns/1ps

module pixel_scanout import video_pkg::*; (
    input  wire logic         clk,
    input  wire logic         reset_i,
    input  wire timing_t      timing_i,
    input  wire logic [7:0]   border_color_i,
    input  wire pixel_group_t group_i,
    input  wire logic         group_valid_i,
    output logic              group_ready_o,
    output logic      [7:0]   color_index_o,
    output logic              hsync_o,
    output logic              vsync_o,
    output logic              dv_de_o,
    output logic              vblank_o
);

    pixel_group_t shift_q;          // head pixel in [7]
    logic [2:0]   pix_cnt;          // position within current group
    logic         full;

    assign group_ready_o = !full || (timing_i.de && pix_cnt == 3'd7);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            full          <= 1'b0;
            pix_cnt       <= 3'd0;
            color_index_o <= 8'h00;
            hsync_o       <= ~H_SYNC_POLARITY;
            vsync_o       <= ~V_SYNC_POLARITY;
            dv_de_o       <= 1'b0;
            vblank_o      <= 1'b0;
        end else begin
            hsync_o  <= timing_i.hsync ? H_SYNC_POLARITY : ~H_SYNC_POLARITY;
            vsync_o  <= timing_i.vsync ? V_SYNC_POLARITY : ~V_SYNC_POLARITY;
            dv_de_o  <= timing_i.de;
            vblank_o <= timing_i.vblank;
            color_index_o <= (timing_i.de && full) ? shift_q[7] : border_color_i;  // underrun shows border
            if (timing_i.de) begin
                pix_cnt <= pix_cnt + 3'd1;
                shift_q <= {shift_q[6:0], 8'h00};
                if (pix_cnt == 3'd7) begin
                    full <= 1'b0;           // group used up
                end
            end
            if (group_valid_i && group_ready_o) begin
                shift_q <= group_i;
                full    <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/video_gen.sv
`default_nettype none
`timescale 1ns/1ps

module video_gen import video_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset_i,
    input  wire logic        reg_wr_i,          // write strobe, taken the same cycle
    input  wire logic [4:0]  reg_num_w_i,
    input  wire logic [4:0]  reg_num_r_i,
    input  wire logic [15:0] reg_data_i,
    output logic      [15:0] reg_data_o,
    output logic      [3:0]  intr_o,
    output logic             vram_sel_o,
    output logic      [15:0] vram_addr_o,
    input  wire logic [15:0] vram_data_i,       // valid the clock after sel
    output logic      [7:0]  color_index_o,
    output logic             hsync_o,
    output logic             vsync_o,
    output logic             dv_de_o,
    output logic             vblank_o
);

    timing_t      timing;
    plane_cfg_t   cfg;
    logic [7:0]   border_color;
    pixel_group_t group;
    logic         group_valid;
    logic         group_ready;

    video_regs u_regs (
        .clk            (clk),
        .reset_i        (reset_i),
        .reg_wr_i       (reg_wr_i),
        .reg_num_w_i    (reg_num_w_i),
        .reg_num_r_i    (reg_num_r_i),
        .reg_data_i     (reg_data_i),
        .reg_data_o     (reg_data_o),
        .timing_i       (timing),
        .cfg_o          (cfg),
        .border_color_o (border_color),
        .intr_o         (intr_o)
    );

    video_timing u_timing (
        .clk      (clk),
        .reset_i  (reset_i),
        .timing_o (timing)
    );

    bitmap_fetch u_fetch (
        .clk           (clk),
        .reset_i       (reset_i),
        .timing_i      (timing),
        .cfg_i         (cfg),
        .vram_sel_o    (vram_sel_o),
        .vram_addr_o   (vram_addr_o),
        .vram_data_i   (vram_data_i),
        .group_o       (group),
        .group_valid_o (group_valid),
        .group_ready_i (group_ready)
    );

    pixel_scanout u_scanout (
        .clk            (clk),
        .reset_i        (reset_i),
        .timing_i       (timing),
        .border_color_i (border_color),
        .group_i        (group),
        .group_valid_i  (group_valid),
        .group_ready_o  (group_ready),
        .color_index_o  (color_index_o),
        .hsync_o        (hsync_o),
        .vsync_o        (vsync_o),
        .dv_de_o        (dv_de_o),
        .vblank_o       (vblank_o)
    );

endmodule

`default_nettype wire

// File: verification/video_gen_tb.sv
`default_nettype none
`timescale 1ns/1ps

module video_gen_tb
    import video_pkg::*;
();

    logic        clk = 1'b0;
    logic        reset_i;
    logic        reg_wr_i;
    logic [4:0]  reg_num_w_i;
    logic [4:0]  reg_num_r_i;
    logic [15:0] reg_data_i;
    logic [15:0] reg_data_o;
    logic [3:0]  intr_o;
    logic        vram_sel_o;
    logic [15:0] vram_addr_o;
    logic [15:0] vram_data_i = 16'h0000;
    logic [7:0]  color_index_o;
    logic        hsync_o;
    logic        vsync_o;
    logic        dv_de_o;
    logic        vblank_o;

    int seed = 173;
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    // register contents as written, and the copy the model takes per frame
    logic [7:0]  sh_border = 8'h00;
    logic [7:0]  sh_cb = 8'h00;
    logic [1:0]  sh_bpp = 2'd0;
    logic        sh_blank = 1'b0;
    logic [15:0] sh_disp = 16'h0000;
    logic [15:0] sh_len = 16'd8;
    logic [7:0]  m_cb;
    logic [1:0]  m_bpp;
    logic        m_blank;
    logic [15:0] m_disp;
    logic [15:0] m_len;
    logic        m_armed = 1'b0;            // no plane until the first frame end

    // output monitor state
    logic [7:0] border_d1 = 8'h00;          // border register as the DUT holds it
    logic [7:0] border_d2 = 8'h00;          // as it reaches color_index_o
    logic prev_vb = 1'b0;
    logic prev_de = 1'b0;
    logic prev_hs = 1'b1;
    logic seg_seen = 1'b0;
    logic hs_seen = 1'b0;
    int frame_clk = 0;
    int line_clk = 0;
    int hs_run = 0;
    int de_lines = 0;
    int vs_clk = 0;
    int vb_low = 0;
    int px_idx = 0;
    int line_idx = 0;
    int frames = 0;
    int frame_intr3 = 0;
    int sw3_total = 0;
    int sw3_mark = 0;
    int intr_seen [3] = '{0, 0, 0};
    int intr_exp [3] = '{0, 0, 0};

    video_gen DUT (.*);

    always #20 clk = ~clk;

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // fixed scramble of the address
    function automatic logic [15:0] vram_word(input logic [15:0] a);
        logic [15:0] m;
        m = a * 16'h9E37;
        return m ^ {a[7:0], a[15:8]} ^ 16'h3C5A;
    endfunction

    function automatic logic [7:0] expected_pixel(input int line, input int px);
        logic [15:0] start;
        logic [15:0] w;
        logic [3:0]  nib;
        int          g;
        int          j;
        g = px / 8;
        j = px % 8;
        start = m_disp + 16'(line) * m_len;
        if (m_bpp == 2'd2) begin                    // two words per group with nibbles msb first
            w = vram_word(start + 16'(2 * g + j / 4));
            nib = w[15 - 4 * (j % 4) -: 4];
        end else begin                              // bit set picks the fore nibble
            w = vram_word(start + 16'(g));
            nib = w[7 - j] ? w[11:8] : w[15:12];
        end
        return {m_cb[7:4], nib};
    endfunction

    function automatic logic implemented_reg(input logic [4:0] num);
        case (num)
            XR_VID_CTRL, XR_SCANLINE, XR_VID_HSIZE, XR_VID_VSIZE,
            XR_PA_GFX_CTRL, XR_PA_DISP_ADDR, XR_PA_LINE_LEN: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic reg_write(input logic [4:0] num, input logic [15:0] data);
        reg_wr_i    <= 1'b1;
        reg_num_w_i <= num;
        reg_data_i  <= data;
        @(posedge clk);
        reg_wr_i <= 1'b0;
        case (num)
            XR_VID_CTRL: begin
                sh_border = data[15:8];
                for (int b = 0; b < 3; b++) intr_exp[b] += data[b];
                sw3_total += data[3];
            end
            XR_PA_GFX_CTRL: begin
                sh_cb    = data[15:8];
                sh_blank = data[7];
                sh_bpp   = data[5:4];
            end
            XR_PA_DISP_ADDR: sh_disp = data;
            XR_PA_LINE_LEN:  sh_len = data;
            default: ;
        endcase
    endtask

    task automatic read_check(input logic [4:0] num, input logic [15:0] exp);
        reg_num_r_i <= num;
        @(posedge clk);
        @(posedge clk);                             // read data is registered
        check_value(reg_data_o, exp, $sformatf("readback of register %0h", num));
    endtask

    // next frame's configuration is written while in vblank
    task automatic setup_frame(input int step);
        logic [15:0] d;
        logic [1:0]  bpp;
        logic        blank;
        case (step)
            1, 2, 5, 8: bpp = 2'd2;
            4:          bpp = 2'd3;                 // unused code acts as 1 bpp
            default:    bpp = 2'd0;
        endcase
        blank = (step == 3) || (step == 7);
        d = 16'($random(seed));
        reg_write(XR_PA_GFX_CTRL, {d[15:8], blank, d[6], bpp, d[3:0]});
        reg_write(XR_PA_DISP_ADDR, 16'($random(seed)));
        reg_write(XR_PA_LINE_LEN, 16'($random(seed)));
        reg_write(XR_VID_CTRL, 16'($random(seed)));
    endtask

    task automatic wait_frame_start();
        while (vblank_o !== 1'b1) @(posedge clk);
        while (vblank_o !== 1'b0) @(posedge clk);
    endtask

    // VRAM model returns data one clock after sel
    always @(posedge clk) begin
        if (vram_sel_o) vram_data_i <= vram_word(vram_addr_o);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == 14000) begin
            $display("timeout: test did not complete within 14000 clock cycles");
            $display("Errors found");
            $finish;
        end
    end

    always @(posedge clk) begin
        logic [7:0] exp;
        if (!reset_i) begin
            if (prev_vb && !vblank_o) begin         // line 0 of a new frame
                if (seg_seen) begin
                    check_value(frame_clk, 968, "clocks per frame");
                    check_value(de_lines, 6, "lines with de per frame");
                    check_value(vs_clk, 176, "vsync clocks per frame");
                    check_value(vb_low, 528, "clocks with vblank low per frame");
                end
                check_value(frame_intr3, 1 + sw3_total - sw3_mark,
                            "intr bit 3 pulses in frame");
                seg_seen = 1'b1;
                frames++;
                {frame_clk, de_lines, vs_clk, vb_low, line_idx, frame_intr3} = '0;
                sw3_mark = sw3_total;
                {m_cb, m_bpp, m_blank, m_disp, m_len} = {sh_cb, sh_bpp, sh_blank, sh_disp, sh_len};
                m_armed = 1'b1;
            end
            if (prev_hs && !hsync_o) begin          // hsync is active low
                if (hs_seen) check_value(line_clk, 88, "clocks per line");
                hs_seen = 1'b1;
                line_clk = 0;
            end
            line_clk++;
            if (!hsync_o) begin
                hs_run++;
            end else if (hs_run != 0) begin
                check_value(hs_run, 8, "hsync clocks per line");
                hs_run = 0;
            end
            if (dv_de_o) begin
                exp = (!m_armed || m_blank) ? border_d2 : expected_pixel(line_idx, px_idx);
                check_value(color_index_o, exp,
                            $sformatf("pixel %0d of line %0d", px_idx, line_idx));
                px_idx++;
            end else begin
                check_value(color_index_o, border_d2, "border colour outside de");
                if (prev_de) begin
                    check_value(px_idx, 64, "de clocks per line");
                    line_idx++;
                    de_lines++;
                    px_idx = 0;
                end
            end
            check_value(dv_de_o && vblank_o, 1'b0, "de during vblank");
            if (m_armed && m_blank) check_value(vram_sel_o, 1'b0, "VRAM read in blank frame");
            vs_clk += (vsync_o == 1'b0);
            vb_low += !vblank_o;
            frame_clk++;
            for (int b = 0; b < 3; b++) intr_seen[b] += intr_o[b];
            frame_intr3 += intr_o[3];
            border_d2 = border_d1;
            if (reg_wr_i && reg_num_w_i == XR_VID_CTRL) border_d1 = reg_data_i[15:8];
            prev_vb = vblank_o;
            prev_de = dv_de_o;
            prev_hs = hsync_o;
        end
    end

    initial begin
        logic [15:0] d;
        reset_i     <= 1'b1;
        reg_wr_i    <= 1'b0;
        reg_num_w_i <= 5'h00;
        reg_num_r_i <= 5'h00;
        reg_data_i  <= 16'h0000;
        repeat (16) @(posedge clk);
        reset_i <= 1'b0;
        @(posedge clk);
        repeat (4) begin                            // unused bits of writable registers read 0
            d = 16'($random(seed));
            reg_write(XR_VID_CTRL, d);
            read_check(XR_VID_CTRL, {d[15:8], 8'h00});
            d = 16'($random(seed));
            reg_write(XR_PA_GFX_CTRL, d);
            read_check(XR_PA_GFX_CTRL, d & 16'hFFB0);
            d = 16'($random(seed));
            reg_write(XR_PA_DISP_ADDR, d);
            read_check(XR_PA_DISP_ADDR, d);
            d = 16'($random(seed));
            reg_write(XR_PA_LINE_LEN, d);
            read_check(XR_PA_LINE_LEN, d);
        end
        reg_write(XR_VID_HSIZE, 16'($random(seed)));
        reg_write(XR_VID_VSIZE, 16'($random(seed)));
        reg_write(XR_SCANLINE, 16'($random(seed)));
        reg_write(5'h1F, 16'($random(seed)));
        read_check(XR_VID_HSIZE, 16'd64);
        read_check(XR_VID_VSIZE, 16'd6);
        read_check(XR_VID_CTRL, {sh_border, 8'h00});
        read_check(XR_PA_GFX_CTRL, {sh_cb, sh_blank, 1'b0, sh_bpp, 4'h0});
        read_check(XR_PA_DISP_ADDR, sh_disp);
        read_check(XR_PA_LINE_LEN, sh_len);
        for (int n = 0; n < 32; n++) begin
            if (!implemented_reg(5'(n))) begin
                read_check(5'(n), 16'h0000);
            end
        end
        setup_frame(0);
        wait_frame_start();
        for (int step = 1; step <= 8; step++) begin
            while (vsync_o !== 1'b0) @(posedge clk);
            setup_frame(step);
            while (vsync_o === 1'b0) @(posedge clk);
        end
        wait_frame_start();
        wait_frame_start();
        repeat (2) @(posedge clk);
        check_value(frames, 10, "frames seen by the monitor");
        for (int b = 0; b < 3; b++) begin
            check_value(intr_seen[b], intr_exp[b], $sformatf("software pulses on intr bit %0d", b));
        end
        $display("checks run %0d, mismatches %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
rtl/video_pkg.sv
rtl/video_timing.sv
rtl/video_regs.sv
rtl/bitmap_fetch.sv
rtl/pixel_scanout.sv
rtl/video_gen.sv
verification/video_gen_tb.sv
